/* design/decode_pkg.sv */
/* Shared widths, codes and pipeline structs for the RV64I decode stage.
   Only the opcodes listed here are decoded; all others give all-zero controls. */

package decode_pkg;

    // ------------------------------------------------------------------
    // Basic widths.
    // ------------------------------------------------------------------
    localparam int XLEN       = 64;
    localparam int ILEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    typedef logic [XLEN-1:0]       data_t;
    typedef logic [XLEN-1:0]       addr_t;
    typedef logic [ILEN-1:0]       instr_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    typedef logic [6:0] opcode_t;
    typedef logic [4:0] alu_ctrl_t;
    typedef logic [2:0] result_src_t;
    typedef logic [2:0] imm_src_t;

    // ------------------------------------------------------------------
    // Opcodes.
    // ------------------------------------------------------------------
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_LUI    = 7'b0110111;

    // ALU operations.
    localparam alu_ctrl_t ALU_ADD    = 5'b00000;
    localparam alu_ctrl_t ALU_SUB    = 5'b00001;
    localparam alu_ctrl_t ALU_SLL    = 5'b00010;
    localparam alu_ctrl_t ALU_SLT    = 5'b00011;
    localparam alu_ctrl_t ALU_SLTU   = 5'b00100;
    localparam alu_ctrl_t ALU_XOR    = 5'b00101;
    localparam alu_ctrl_t ALU_SRL    = 5'b00110;
    localparam alu_ctrl_t ALU_SRA    = 5'b00111;
    localparam alu_ctrl_t ALU_OR     = 5'b01000;
    localparam alu_ctrl_t ALU_AND    = 5'b01001;
    localparam alu_ctrl_t ALU_PASS_B = 5'b01010;

    // Write-back source select.
    localparam result_src_t RES_ALU = 3'b000;
    localparam result_src_t RES_MEM = 3'b001;
    localparam result_src_t RES_PC4 = 3'b010;
    localparam result_src_t RES_IMM = 3'b011;

    // Immediate formats.
    localparam imm_src_t IMM_I = 3'b000;
    localparam imm_src_t IMM_S = 3'b001;
    localparam imm_src_t IMM_B = 3'b010;
    localparam imm_src_t IMM_J = 3'b011;
    localparam imm_src_t IMM_U = 3'b100;

    // ------------------------------------------------------------------
    // Pipeline structs.
    // ------------------------------------------------------------------
    typedef struct packed {
        result_src_t result_src;
        alu_ctrl_t   alu_control;
        logic        mem_we;
        logic        reg_we;
        logic        alu_src;
        logic        branch;
        logic        jump;
    } decode_ctrl_t;

    typedef struct packed {
        addr_t     pc;
        addr_t     pc_plus4;
        data_t     imm_ext;
        data_t     rs1_data;
        data_t     rs2_data;
        reg_addr_t rs1_addr;
        reg_addr_t rs2_addr;
        reg_addr_t rd_addr;
    } decode_data_t;

endpackage

/* design/control_unit.sv */
/* Combinational main decoder for OP, OP-IMM, LOAD, STORE, BRANCH, JAL, JALR, LUI.
   Unknown opcodes produce all-zero controls with the I immediate format. */

`timescale 1ns/1ps

module control_unit (
    input  decode_pkg::opcode_t      i_op,
    input  logic [2:0]               i_funct3,
    input  logic                     i_funct7_5,
    output decode_pkg::decode_ctrl_t o_ctrl,
    output decode_pkg::imm_src_t     o_imm_src
);

    import decode_pkg::*;

    alu_ctrl_t s_alu_funct;
    logic      s_alt_op;

    // Bit 30 selects SUB only for register-register ops; SRA/SRAI use it in both.
    assign s_alt_op = i_funct7_5 & (i_op == OPC_OP);

    // ------------------------------------------------------------------
    // ALU decode from funct3.
    // ------------------------------------------------------------------
    always_comb begin
        case (i_funct3)
            3'b000:  s_alu_funct = s_alt_op ? ALU_SUB : ALU_ADD;
            3'b001:  s_alu_funct = ALU_SLL;
            3'b010:  s_alu_funct = ALU_SLT;
            3'b011:  s_alu_funct = ALU_SLTU;
            3'b100:  s_alu_funct = ALU_XOR;
            3'b101:  s_alu_funct = i_funct7_5 ? ALU_SRA : ALU_SRL;
            3'b110:  s_alu_funct = ALU_OR;
            default: s_alu_funct = ALU_AND;
        endcase
    end

    // ------------------------------------------------------------------
    // Main decoder.
    // ------------------------------------------------------------------
    always_comb begin
        o_ctrl    = '0;
        o_imm_src = IMM_I;

        case (i_op)
            OPC_OP: begin
                o_ctrl.alu_control = s_alu_funct;
                o_ctrl.reg_we      = 1'b1;
            end
            OPC_OP_IMM: begin
                o_ctrl.alu_control = s_alu_funct;
                o_ctrl.alu_src     = 1'b1;
                o_ctrl.reg_we      = 1'b1;
            end
            OPC_LOAD: begin
                o_ctrl.alu_control = ALU_ADD;
                o_ctrl.alu_src     = 1'b1;
                o_ctrl.reg_we      = 1'b1;
                o_ctrl.result_src  = RES_MEM;
            end
            OPC_STORE: begin
                o_ctrl.alu_control = ALU_ADD;
                o_ctrl.alu_src     = 1'b1;
                o_ctrl.mem_we      = 1'b1;
                o_imm_src          = IMM_S;
            end
            OPC_BRANCH: begin
                // Compare by subtraction in execute.
                o_ctrl.alu_control = ALU_SUB;
                o_ctrl.branch      = 1'b1;
                o_imm_src          = IMM_B;
            end
            OPC_JAL: begin
                o_ctrl.jump       = 1'b1;
                o_ctrl.reg_we     = 1'b1;
                o_ctrl.result_src = RES_PC4;
                o_imm_src         = IMM_J;
            end
            OPC_JALR: begin
                o_ctrl.alu_control = ALU_ADD;
                o_ctrl.alu_src     = 1'b1;
                o_ctrl.jump        = 1'b1;
                o_ctrl.reg_we      = 1'b1;
                o_ctrl.result_src  = RES_PC4;
            end
            OPC_LUI: begin
                o_ctrl.alu_control = ALU_PASS_B;
                o_ctrl.reg_we      = 1'b1;
                o_ctrl.result_src  = RES_IMM;
                o_imm_src          = IMM_U;
            end
            default: begin
                // Unsupported opcode acts as a bubble.
                o_ctrl = '0;
            end
        endcase
    end

endmodule

/* design/extend_imm.sv */
/* Builds the I, S, B, J and U immediates from instruction bits 31..7.
   All formats sign-extend from bit 31; unknown selects give zero. */

`timescale 1ns/1ps

module extend_imm (
    input  decode_pkg::imm_src_t i_imm_src,
    input  logic [24:0]          i_imm,
    output decode_pkg::data_t    o_imm_ext
);

    import decode_pkg::*;

    logic s_sign;

    // i_imm[k] holds instruction bit k+7.
    assign s_sign = i_imm[24];

    always_comb begin
        case (i_imm_src)
            IMM_I: o_imm_ext = {{(XLEN-12){s_sign}}, i_imm[24:13]};
            IMM_S: o_imm_ext = {{(XLEN-12){s_sign}}, i_imm[24:18], i_imm[4:0]};
            IMM_B: begin
                o_imm_ext = {{(XLEN-12){s_sign}}, i_imm[0], i_imm[23:18],
                             i_imm[4:1], 1'b0};
            end
            IMM_J: begin
                o_imm_ext = {{(XLEN-20){s_sign}}, i_imm[12:5], i_imm[13],
                             i_imm[23:14], 1'b0};
            end
            IMM_U: o_imm_ext = {{(XLEN-32){s_sign}}, i_imm[24:5], 12'b0};
            default: o_imm_ext = '0;
        endcase
    end

endmodule

/* design/register_file.sv */
/* 32 x 64-bit register file, two combinational reads, one write per clock.
   x0 reads zero; a same-cycle write to a read register is bypassed. */

`timescale 1ns/1ps

module register_file (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  decode_pkg::reg_addr_t i_rs1_addr,
    input  decode_pkg::reg_addr_t i_rs2_addr,
    input  logic                  i_we,
    input  decode_pkg::reg_addr_t i_rd_addr,
    input  decode_pkg::data_t     i_rd_data,
    output decode_pkg::data_t     o_rs1_data,
    output decode_pkg::data_t     o_rs2_data
);

    import decode_pkg::*;

    data_t r_regs [NUM_REGS];
    logic  s_wr_valid;

    // Writes to x0 are dropped.
    assign s_wr_valid = i_we & (i_rd_addr != '0);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                r_regs[i] <= '0;
            end
        end else if (s_wr_valid) begin
            r_regs[i_rd_addr] <= i_rd_data;
        end
    end

    // Read ports with write-through.
    assign o_rs1_data = (i_rs1_addr == '0) ? '0 :
                        (s_wr_valid && i_rd_addr == i_rs1_addr) ? i_rd_data :
                        r_regs[i_rs1_addr];

    assign o_rs2_data = (i_rs2_addr == '0) ? '0 :
                        (s_wr_valid && i_rd_addr == i_rs2_addr) ? i_rd_data :
                        r_regs[i_rs2_addr];

endmodule

/* design/preg_decode.sv */
/* Decode/execute pipeline register, loaded every clock with no stall.
   Reset or flush loads zero, which is a bubble downstream. */

`timescale 1ns/1ps

module preg_decode (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_flush,
    input  decode_pkg::decode_ctrl_t i_ctrl,
    input  decode_pkg::decode_data_t i_data,
    output decode_pkg::decode_ctrl_t o_ctrl,
    output decode_pkg::decode_data_t o_data
);

    logic s_clear;

    // Reset and flush both give the same all-zero result.
    assign s_clear = !i_rst_n || i_flush;

    // ------------------------------------------------------------------
    // Control half.
    // ------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (s_clear) begin
            o_ctrl <= '0;
        end else begin
            o_ctrl <= i_ctrl;
        end
    end

    // ------------------------------------------------------------------
    // Data half.
    // ------------------------------------------------------------------
    // Cleared too, so a bubble carries no stale addresses.
    always_ff @(posedge i_clk) begin
        if (s_clear) begin
            o_data <= '0;
        end else begin
            o_data <= i_data;
        end
    end

endmodule

/* design/decode_stage.sv */
/* RV64I decode stage top: field split, control, immediate, register file, D/E register.
   No hazard detection or forwarding; outputs follow inputs by exactly one clock. */

`timescale 1ns/1ps

module decode_stage (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  decode_pkg::instr_t       i_instr,
    input  decode_pkg::addr_t        i_pc,
    input  decode_pkg::addr_t        i_pc_plus4,
    input  logic                     i_wb_we,
    input  decode_pkg::reg_addr_t    i_wb_addr,
    input  decode_pkg::data_t        i_wb_data,
    input  logic                     i_flush,
    output decode_pkg::decode_ctrl_t o_ctrl,
    output decode_pkg::decode_data_t o_data
);

    import decode_pkg::*;

    // ------------------------------------------------------------------
    // Instruction fields.
    // ------------------------------------------------------------------
    opcode_t      s_op;
    logic [2:0]   s_funct3;
    logic         s_funct7_5;
    logic [24:0]  s_imm_bits;
    reg_addr_t    s_rs1_addr;
    reg_addr_t    s_rs2_addr;
    reg_addr_t    s_rd_addr;

    decode_ctrl_t s_ctrl;
    imm_src_t     s_imm_src;
    data_t        s_imm_ext;
    data_t        s_rs1_data;
    data_t        s_rs2_data;
    decode_data_t s_data;

    assign s_op       = i_instr[6:0];
    assign s_funct3   = i_instr[14:12];
    assign s_funct7_5 = i_instr[30];
    assign s_imm_bits = i_instr[31:7];
    assign s_rs1_addr = i_instr[19:15];
    assign s_rs2_addr = i_instr[24:20];
    assign s_rd_addr  = i_instr[11:7];

    // ------------------------------------------------------------------
    // Decode blocks.
    // ------------------------------------------------------------------
    control_unit control_unit_inst (
        .i_op       (s_op),
        .i_funct3   (s_funct3),
        .i_funct7_5 (s_funct7_5),
        .o_ctrl     (s_ctrl),
        .o_imm_src  (s_imm_src)
    );

    extend_imm extend_imm_inst (
        .i_imm_src (s_imm_src),
        .i_imm     (s_imm_bits),
        .o_imm_ext (s_imm_ext)
    );

    register_file register_file_inst (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_rs1_addr (s_rs1_addr),
        .i_rs2_addr (s_rs2_addr),
        .i_we       (i_wb_we),
        .i_rd_addr  (i_wb_addr),
        .i_rd_data  (i_wb_data),
        .o_rs1_data (s_rs1_data),
        .o_rs2_data (s_rs2_data)
    );

    // Payload for the execute stage.
    assign s_data.pc       = i_pc;
    assign s_data.pc_plus4 = i_pc_plus4;
    assign s_data.imm_ext  = s_imm_ext;
    assign s_data.rs1_data = s_rs1_data;
    assign s_data.rs2_data = s_rs2_data;
    assign s_data.rs1_addr = s_rs1_addr;
    assign s_data.rs2_addr = s_rs2_addr;
    assign s_data.rd_addr  = s_rd_addr;

    preg_decode preg_decode_inst (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_flush (i_flush),
        .i_ctrl  (s_ctrl),
        .i_data  (s_data),
        .o_ctrl  (o_ctrl),
        .o_data  (o_data)
    );

endmodule

/* test/decode_stage_checker.sv */
/* Concurrent checks on the decode stage controls, bound into decode_stage.
   fail_count holds the number of failed assertions so far. */

`timescale 1ns/1ps

module decode_stage_checker (
    input logic                     i_clk,
    input logic                     i_rst_n,
    input logic                     i_flush,
    input decode_pkg::decode_ctrl_t i_ctrl
);

    int fail_count = 0;

    // Reset or flush at an edge leaves a bubble after it.
    a_reset_bubble: assert property (@(posedge i_clk) !i_rst_n |=> i_ctrl == '0)
        else begin
            $error("Controls not cleared after a reset cycle");
            fail_count++;
        end

    a_flush_bubble: assert property (@(posedge i_clk) i_flush |=> i_ctrl == '0)
        else begin
            $error("Controls not cleared after a flush cycle");
            fail_count++;
        end

    // No instruction both stores and writes a register.
    a_mem_reg_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_ctrl.mem_we && i_ctrl.reg_we))
        else begin
            $error("mem_we and reg_we both high");
            fail_count++;
        end

    a_branch_jump_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_ctrl.branch && i_ctrl.jump))
        else begin
            $error("branch and jump both high");
            fail_count++;
        end

endmodule

bind decode_stage decode_stage_checker decode_stage_checker_inst (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_flush (i_flush),
    .i_ctrl  (o_ctrl)
);

/* test/decode_stage_tb.sv */
/* Random instructions, write-backs and flushes; one-cycle latency is assumed.
   Expected outputs come from a reference decoder and a shadow register array. */

`timescale 1ns/1ps

module decode_stage_tb;

    import decode_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_TESTS    = 2000;

    logic         clk;
    logic         rst_n;
    instr_t       instr;
    addr_t        pc;
    addr_t        pc_plus4;
    logic         wb_we;
    reg_addr_t    wb_addr;
    data_t        wb_data;
    logic         flush;
    decode_ctrl_t dut_ctrl;
    decode_data_t dut_data;

    data_t        shadow [NUM_REGS];
    decode_ctrl_t next_ctrl;
    decode_data_t next_data;
    decode_ctrl_t exp_ctrl;
    decode_data_t exp_data;
    logic [31:0]  rng_state;
    int           err_count;

    decode_stage decode_stage_inst (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_instr    (instr),
        .i_pc       (pc),
        .i_pc_plus4 (pc_plus4),
        .i_wb_we    (wb_we),
        .i_wb_addr  (wb_addr),
        .i_wb_data  (wb_data),
        .i_flush    (flush),
        .o_ctrl     (dut_ctrl),
        .o_data     (dut_data)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // ------------------------------------------------------------------
    // Random numbers and reference model.
    // ------------------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Mostly legal opcodes, the rest raw random bits.
    function automatic opcode_t pick_opcode(input logic [3:0] idx, input opcode_t raw);
        if (idx >= 4'd13) begin
            return raw;
        end
        case (idx[2:0])
            3'd0:    return OPC_OP;
            3'd1:    return OPC_OP_IMM;
            3'd2:    return OPC_LOAD;
            3'd3:    return OPC_STORE;
            3'd4:    return OPC_BRANCH;
            3'd5:    return OPC_JAL;
            3'd6:    return OPC_JALR;
            default: return OPC_LUI;
        endcase
    endfunction

    function automatic void ref_decode(input instr_t ins, output decode_ctrl_t c,
                                       output data_t imm);
        alu_ctrl_t alu;
        case (ins[14:12])
            3'b000:  alu = (ins[30] && ins[6:0] == OPC_OP) ? ALU_SUB : ALU_ADD;
            3'b001:  alu = ALU_SLL;
            3'b010:  alu = ALU_SLT;
            3'b011:  alu = ALU_SLTU;
            3'b100:  alu = ALU_XOR;
            3'b101:  alu = ins[30] ? ALU_SRA : ALU_SRL;
            3'b110:  alu = ALU_OR;
            default: alu = ALU_AND;
        endcase
        c   = '0;
        imm = {{52{ins[31]}}, ins[31:20]};
        // Field order: result_src, alu_control, mem_we, reg_we, alu_src, branch, jump.
        case (ins[6:0])
            OPC_OP:     c = '{RES_ALU, alu, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
            OPC_OP_IMM: c = '{RES_ALU, alu, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0};
            OPC_LOAD:   c = '{RES_MEM, ALU_ADD, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0};
            OPC_JALR:   c = '{RES_PC4, ALU_ADD, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1};
            OPC_STORE: begin
                c   = '{RES_ALU, ALU_ADD, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0};
                imm = {{52{ins[31]}}, ins[31:25], ins[11:7]};
            end
            OPC_BRANCH: begin
                c   = '{RES_ALU, ALU_SUB, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
                imm = {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            OPC_JAL: begin
                c   = '{RES_PC4, ALU_ADD, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1};
                imm = {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            OPC_LUI: begin
                c   = '{RES_IMM, ALU_PASS_B, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
                imm = {{32{ins[31]}}, ins[31:12], 12'b0};
            end
            default: c = '0;
        endcase
    endfunction

    // Shadow read with x0 at zero and same-cycle write-through.
    function automatic data_t read_shadow(input reg_addr_t a);
        if (a == '0) begin
            return '0;
        end
        if (wb_we && wb_addr == a) begin
            return wb_data;
        end
        return shadow[a];
    endfunction

    // ------------------------------------------------------------------
    // Stimulus.
    // ------------------------------------------------------------------
    task automatic apply_inputs(input instr_t ins, input addr_t pc_val, input logic we,
                                input reg_addr_t wa, input data_t wd, input logic fl);
        decode_ctrl_t c;
        data_t        imm;
        instr    = ins;
        pc       = pc_val;
        pc_plus4 = pc_val + 64'd4;
        wb_we    = we;
        wb_addr  = wa;
        wb_data  = wd;
        flush    = fl;
        ref_decode(ins, c, imm);
        next_ctrl = '0;
        next_data = '0;
        if (!fl) begin
            next_ctrl          = c;
            next_data.pc       = pc_val;
            next_data.pc_plus4 = pc_val + 64'd4;
            next_data.imm_ext  = imm;
            next_data.rs1_data = read_shadow(ins[19:15]);
            next_data.rs2_data = read_shadow(ins[24:20]);
            next_data.rs1_addr = ins[19:15];
            next_data.rs2_addr = ins[24:20];
            next_data.rd_addr  = ins[11:7];
        end
        // Stored at the coming edge.
        if (we && wa != '0) begin
            shadow[wa] = wd;
        end
    endtask

    task automatic drive_random();
        logic [31:0] r;
        logic [31:0] sel;
        instr_t      ins;
        reg_addr_t   wa;
        addr_t       pc_val;
        data_t       wd;
        r      = next_rand();
        sel    = next_rand();
        ins    = {r[31:7], pick_opcode(sel[3:0], sel[22:16])};
        pc_val = {next_rand(), next_rand()} & ~64'd3;
        wd     = {next_rand(), next_rand()};
        wa     = sel[8:4];
        // Some write-backs hit rs1 to exercise the bypass.
        if (sel[11:9] == 3'd0) begin
            wa = ins[19:15];
        end
        apply_inputs(ins, pc_val, sel[12], wa, wd, sel[15:13] == 3'd0);
    endtask

    // ------------------------------------------------------------------
    // Expectation pipeline and compare.
    // ------------------------------------------------------------------
    always @(posedge clk) begin
        exp_ctrl <= next_ctrl;
        exp_data <= next_data;
    end

    always @(negedge clk) begin
        assert (dut_ctrl === exp_ctrl) else begin
            err_count++;
            $display("ERROR %0t: o_ctrl is %h, expected %h", $time, dut_ctrl, exp_ctrl);
        end
        assert (dut_data === exp_data) else begin
            err_count++;
            $display("ERROR %0t: o_data is %h, expected %h", $time, dut_data, exp_data);
        end
    end

    initial begin
        #((NUM_TESTS + 20) * CLK_PERIOD);
        $display("Watchdog expired before the tests finished");
        $display("Done: errors found");
        $finish;
    end

    initial begin
        rng_state = 32'd27499;
        err_count = 0;
        rst_n     = 1'b0;
        // A live JAL and a write-back to x31 during reset; both must be squashed.
        instr     = 32'hFFFF_F0EF;
        pc        = 64'h1000;
        pc_plus4  = 64'h1004;
        wb_we     = 1'b1;
        wb_addr   = 5'd31;
        wb_data   = 64'h0123_4567_89AB_CDEF;
        flush     = 1'b0;
        next_ctrl = '0;
        next_data = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            shadow[i] = '0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        assert (dut_ctrl == '0 && dut_data == '0) else begin
            err_count++;
            $display("ERROR %0t: outputs not zero after reset", $time);
        end
        rst_n = 1'b1;
        for (int n = 0; n < NUM_TESTS; n++) begin
            drive_random();
            @(negedge clk);
        end
        apply_inputs('0, '0, 1'b0, '0, '0, 1'b0);
        repeat (3) @(negedge clk);
        @(posedge clk);
        #1;
        $display("Summary: %0d compare errors, %0d assertion failures", err_count,
                 decode_stage_inst.decode_stage_checker_inst.fail_count);
        if (err_count == 0 && decode_stage_inst.decode_stage_checker_inst.fail_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* filelist.f */
design/decode_pkg.sv
design/control_unit.sv
design/extend_imm.sv
design/register_file.sv
design/preg_decode.sv
design/decode_stage.sv
test/decode_stage_checker.sv
test/decode_stage_tb.sv
